// ==== rtl/core_port.sv ====
//----------------------------------------------------------
// Core front end of the request port
// Byte enables go out with loads and stores alike
// Store responses carry lane data that the core ignores
//----------------------------------------------------------

`timescale 1ns/100ps

`include "mem_tile_params.svh"

module core_port (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  mem_tile_pkg::core_req_t core_req_i,
    input  logic                    accept_i,
    input  logic                    rsp_valid_i,
    input  mem_tile_pkg::mem_rsp_t  mem_rsp_i,
    output mem_tile_pkg::mem_req_t  mreq_o,
    output logic                    rsp_valid_o,
    output logic [`MT_WORD_W-1:0]   rsp_data_o
);
    import mem_tile_pkg::*;

    lane_t    req_lane;
    lane_t    lane_q;
    mem_req_t base_req;

    //----------------------------------------------------------
    // Request path
    //----------------------------------------------------------
    assign req_lane = lane_of(core_req_i.addr);

    always_comb begin
        base_req      = '0;
        base_req.addr = core_req_i.addr;
        base_req.op   = core_req_i.is_store ? MEM_STORE : MEM_LOAD;
        base_req.size = core_req_i.size;
    end

    // Data and mask land in the addressed lane only
    assign mreq_o = pack_lane(base_req, core_req_i.wdata, core_req_i.be, req_lane);

    //----------------------------------------------------------
    // Response path
    //----------------------------------------------------------
    // Lane kept so the core may move on after acceptance
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lane_q <= '0;
        end else if (accept_i) begin
            lane_q <= req_lane;
        end
    end

    assign rsp_valid_o = rsp_valid_i;
    assign rsp_data_o  = unpack_lane(mem_rsp_i.rdata, lane_q);

endmodule

// ==== rtl/dport_arbiter.sv ====
//----------------------------------------------------------
// One request in flight, walker has fixed priority
// Requesters must hold their request until accepted
// Exactly one response pulse is expected per accepted request
//----------------------------------------------------------

`timescale 1ns/100ps

module dport_arbiter (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   ptw_valid_i,
    input  logic                   core_valid_i,
    input  mem_tile_pkg::mem_req_t ptw_mreq_i,
    input  mem_tile_pkg::mem_req_t core_mreq_i,
    input  logic                   mem_req_ready_i,
    input  logic                   mem_rsp_valid_i,
    output logic                   mem_req_valid_o,
    output mem_tile_pkg::mem_req_t mem_req_o,
    output logic                   ptw_accept_o,
    output logic                   core_accept_o,
    output logic                   ptw_rsp_valid_o,
    output logic                   core_rsp_valid_o
);
    import mem_tile_pkg::*;

    arb_state_e state_q;
    arb_state_e state_d;
    owner_e     owner_q;
    owner_e     owner_d;
    logic       accept;
    logic       rsp_done;

    //----------------------------------------------------------
    // Next state and owner selection
    //----------------------------------------------------------
    always_comb begin
        state_d = state_q;
        owner_d = owner_q;
        case (state_q)
            ARB_IDLE: begin
                // Walker wins a tie
                if (ptw_valid_i) begin
                    owner_d = OWN_PTW;
                    state_d = ARB_ISSUE;
                end else if (core_valid_i) begin
                    owner_d = OWN_CORE;
                    state_d = ARB_ISSUE;
                end
            end
            ARB_ISSUE: begin
                if (accept) begin
                    state_d = ARB_WAIT;
                end
            end
            ARB_WAIT: begin
                if (mem_rsp_valid_i) begin
                    state_d = ARB_IDLE;
                end
            end
            default: begin
                state_d = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ARB_IDLE;
            owner_q <= OWN_PTW;
        end else begin
            state_q <= state_d;
            owner_q <= owner_d;
        end
    end

    // Request mux follows the latched owner, not the live valids
    assign mem_req_valid_o = (state_q == ARB_ISSUE);
    assign mem_req_o       = (owner_q == OWN_CORE) ? core_mreq_i : ptw_mreq_i;

    assign accept        = mem_req_valid_o && mem_req_ready_i;
    assign ptw_accept_o  = accept && (owner_q == OWN_PTW);
    assign core_accept_o = accept && (owner_q == OWN_CORE);

    assign rsp_done         = (state_q == ARB_WAIT) && mem_rsp_valid_i;
    assign ptw_rsp_valid_o  = rsp_done && (owner_q == OWN_PTW);
    assign core_rsp_valid_o = rsp_done && (owner_q == OWN_CORE);

    //----------------------------------------------------------
    // Protocol checks
    //----------------------------------------------------------
    // Memory must not answer before a request was accepted
    a_rsp_only_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_rsp_valid_i |-> (state_q == ARB_WAIT));

    // Held request stays put, relies on the owner holding its inputs
    a_req_stable_on_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (mem_req_valid_o && !mem_req_ready_i) |=> (mem_req_valid_o && $stable(mem_req_o)));

endmodule

// ==== rtl/mem_tile.sv ====
//----------------------------------------------------------
// Shared data-cache request port for walker and core
// Memory behind the port answers each request exactly once
// Requesters hold valid and payload until their ready
//----------------------------------------------------------

`timescale 1ns/100ps

`include "mem_tile_params.svh"

module mem_tile (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // Walker side
    input  mem_tile_pkg::ptw_req_t  ptw_req_i,
    output logic                    ptw_ready_o,
    output logic                    ptw_rsp_valid_o,
    output logic [`MT_WORD_W-1:0]   ptw_rsp_data_o,
    // Core side
    input  mem_tile_pkg::core_req_t core_req_i,
    output logic                    core_ready_o,
    output logic                    core_rsp_valid_o,
    output logic [`MT_WORD_W-1:0]   core_rsp_data_o,
    // Memory side
    output logic                    mem_req_valid_o,
    output mem_tile_pkg::mem_req_t  mem_req_o,
    input  logic                    mem_req_ready_i,
    input  logic                    mem_rsp_valid_i,
    input  mem_tile_pkg::mem_rsp_t  mem_rsp_i,
    // Events
    output mem_tile_pkg::pmu_cnt_t  pmu_o
);
    import mem_tile_pkg::*;

    mem_req_t ptw_mreq;
    mem_req_t core_mreq;
    logic     ptw_rsp_strobe;
    logic     core_rsp_strobe;

    ptw_port u_ptw_port (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .ptw_req_i   (ptw_req_i),
        .accept_i    (ptw_ready_o),
        .rsp_valid_i (ptw_rsp_strobe),
        .mem_rsp_i   (mem_rsp_i),
        .mreq_o      (ptw_mreq),
        .rsp_valid_o (ptw_rsp_valid_o),
        .rsp_data_o  (ptw_rsp_data_o)
    );

    core_port u_core_port (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .core_req_i  (core_req_i),
        .accept_i    (core_ready_o),
        .rsp_valid_i (core_rsp_strobe),
        .mem_rsp_i   (mem_rsp_i),
        .mreq_o      (core_mreq),
        .rsp_valid_o (core_rsp_valid_o),
        .rsp_data_o  (core_rsp_data_o)
    );

    dport_arbiter u_arbiter (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .ptw_valid_i      (ptw_req_i.valid),
        .core_valid_i     (core_req_i.valid),
        .ptw_mreq_i       (ptw_mreq),
        .core_mreq_i      (core_mreq),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_o        (mem_req_o),
        .ptw_accept_o     (ptw_ready_o),
        .core_accept_o    (core_ready_o),
        .ptw_rsp_valid_o  (ptw_rsp_strobe),
        .core_rsp_valid_o (core_rsp_strobe)
    );

    pmu_counters u_pmu (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .ptw_accept_i    (ptw_ready_o),
        .core_accept_i   (core_ready_o),
        .core_is_store_i (core_req_i.is_store),
        .pmu_o           (pmu_o)
    );

endmodule

// ==== rtl/mem_tile_params.svh ====
//----------------------------------------------------------
// Build-time sizes for the shared data-cache request port
// MT_REQ_WORDS must be a power of two, 1 or more
// MT_PTW_CMD_AMO_OR is sized to match MT_PTW_CMD_W
//----------------------------------------------------------

`ifndef MEM_TILE_PARAMS_SVH
`define MEM_TILE_PARAMS_SVH

// Physical address width seen by both requesters
`define MT_PADDR_W 40

// 64-bit words carried by one cache request
`define MT_REQ_WORDS 2

// Width of one data word
`define MT_WORD_W 64

// Walker memory command, RISC-V M_XA* style encoding
`define MT_PTW_CMD_W 5

// The only command the port treats specially, keep 5 bits wide
`define MT_PTW_CMD_AMO_OR 5'h0A

// Performance counter width, counters wrap
`define MT_PMU_CNT_W 32

`endif

// ==== rtl/mem_tile_pkg.sv ====
//----------------------------------------------------------
// Shared types and lane helpers for the request port
// Lane index comes from address bits just above the low three
//----------------------------------------------------------

`include "mem_tile_params.svh"

package mem_tile_pkg;

    // Lane index needs at least one bit even with a single word
    localparam int LANE_W = (`MT_REQ_WORDS > 1) ? $clog2(`MT_REQ_WORDS) : 1;
    localparam int BE_W   = `MT_WORD_W / 8;

    typedef logic [LANE_W-1:0]      lane_t;
    typedef logic [`MT_WORD_W-1:0]  word_t;
    typedef logic [BE_W-1:0]        be_t;
    typedef logic [`MT_PADDR_W-1:0] paddr_t;

    typedef enum logic [1:0] {
        MEM_LOAD   = 2'd0,
        MEM_STORE  = 2'd1,
        MEM_AMO_OR = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,
        ARB_ISSUE = 2'd1,
        ARB_WAIT  = 2'd2
    } arb_state_e;

    typedef enum logic {
        OWN_PTW  = 1'b0,
        OWN_CORE = 1'b1
    } owner_e;

    //----------------------------------------------------------
    // Requester and memory side bundles
    //----------------------------------------------------------
    typedef struct packed {
        logic                     valid;
        paddr_t                   addr;
        logic [`MT_PTW_CMD_W-1:0] cmd;
        logic [2:0]               typ;
        word_t                    data;
    } ptw_req_t;

    typedef struct packed {
        logic       valid;
        paddr_t     addr;
        logic       is_store;
        logic [2:0] size;
        word_t      wdata;
        be_t        be;
    } core_req_t;

    typedef struct packed {
        paddr_t                       addr;
        mem_op_e                      op;
        logic [2:0]                   size;
        word_t [`MT_REQ_WORDS-1:0]    wdata;
        be_t [`MT_REQ_WORDS-1:0]      be;
    } mem_req_t;

    typedef struct packed {
        word_t [`MT_REQ_WORDS-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic [`MT_PMU_CNT_W-1:0] ptw_reqs;
        logic [`MT_PMU_CNT_W-1:0] core_loads;
        logic [`MT_PMU_CNT_W-1:0] core_stores;
    } pmu_cnt_t;

    //----------------------------------------------------------
    // Lane helpers
    //----------------------------------------------------------
    function automatic lane_t lane_of(input paddr_t addr);
        lane_t lane;
        if (`MT_REQ_WORDS == 1) begin
            lane = '0;
        end else begin
            lane = addr[LANE_W+2:3];
        end
        return lane;
    endfunction

    // Other lanes carry zero data and no byte enables
    function automatic mem_req_t pack_lane(input mem_req_t req, input word_t word,
                                           input be_t mask, input lane_t lane);
        mem_req_t res;
        res = req;
        for (int i = 0; i < `MT_REQ_WORDS; i++) begin
            res.wdata[i] = (lane_t'(i) == lane) ? word : '0;
            res.be[i]    = (lane_t'(i) == lane) ? mask : '0;
        end
        return res;
    endfunction

    function automatic word_t unpack_lane(input word_t [`MT_REQ_WORDS-1:0] rdata,
                                          input lane_t lane);
        return rdata[lane];
    endfunction

endpackage

// ==== rtl/pmu_counters.sv ====
//----------------------------------------------------------
// Event counters for the shared request port
// Counts accepted requests only, counters wrap silently
//----------------------------------------------------------

`timescale 1ns/100ps

module pmu_counters (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   ptw_accept_i,
    input  logic                   core_accept_i,
    input  logic                   core_is_store_i,
    output mem_tile_pkg::pmu_cnt_t pmu_o
);
    import mem_tile_pkg::*;

    pmu_cnt_t cnt_q;
    logic     core_load_evt;
    logic     core_store_evt;

    assign core_load_evt  = core_accept_i && !core_is_store_i;
    assign core_store_evt = core_accept_i && core_is_store_i;

    //----------------------------------------------------------
    // Counters
    //----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else begin
            if (ptw_accept_i) begin
                cnt_q.ptw_reqs <= cnt_q.ptw_reqs + 1'b1;
            end
            if (core_load_evt) begin
                cnt_q.core_loads <= cnt_q.core_loads + 1'b1;
            end
            if (core_store_evt) begin
                cnt_q.core_stores <= cnt_q.core_stores + 1'b1;
            end
        end
    end

    assign pmu_o = cnt_q;

endmodule

// ==== rtl/ptw_port.sv ====
//----------------------------------------------------------
// Walker front end of the request port
// Only AMO-OR is decoded, every other command is a load
// Response word comes from the lane captured at acceptance
//----------------------------------------------------------

`timescale 1ns/100ps

`include "mem_tile_params.svh"

module ptw_port (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  mem_tile_pkg::ptw_req_t ptw_req_i,
    input  logic                   accept_i,
    input  logic                   rsp_valid_i,
    input  mem_tile_pkg::mem_rsp_t mem_rsp_i,
    output mem_tile_pkg::mem_req_t mreq_o,
    output logic                   rsp_valid_o,
    output logic [`MT_WORD_W-1:0]  rsp_data_o
);
    import mem_tile_pkg::*;

    logic     is_amo;
    be_t      amo_mask;
    lane_t    req_lane;
    lane_t    lane_q;
    mem_req_t base_req;

    //----------------------------------------------------------
    // Request path, purely combinational
    //----------------------------------------------------------
    assign is_amo   = (ptw_req_i.cmd == `MT_PTW_CMD_AMO_OR);
    assign amo_mask = {BE_W{is_amo}};
    assign req_lane = lane_of(ptw_req_i.addr);

    always_comb begin
        base_req      = '0;
        base_req.addr = ptw_req_i.addr;
        base_req.op   = is_amo ? MEM_AMO_OR : MEM_LOAD;
        // typ already uses the cache size encoding
        base_req.size = ptw_req_i.typ;
    end

    assign mreq_o = pack_lane(base_req, ptw_req_i.data, amo_mask, req_lane);

    //----------------------------------------------------------
    // Response path
    //----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lane_q <= '0;
        end else if (accept_i) begin
            lane_q <= req_lane;
        end
    end

    assign rsp_valid_o = rsp_valid_i;
    assign rsp_data_o  = unpack_lane(mem_rsp_i.rdata, lane_q);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module tb_mem_tile \
    -Mdir obj_dir -o sim_mem_tile || { echo "Build failed"; exit 1; }
out=$(./obj_dir/sim_mem_tile)
echo "$out"
echo "$out" | grep -q -x "TESTBENCH PASSED" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== sim/tb_mem_tile.sv ====
//----------------------------------------------------------
// Directed testbench for the shared request port
// Memory model serves one request at a time, 1 to 5 cycles
// Outputs are sampled on the falling edge
//----------------------------------------------------------

`timescale 1ns/100ps

`include "mem_tile_params.svh"

module tb_mem_tile;
    import mem_tile_pkg::*;

    localparam int MAX_CYCLES = 2000;

    logic      clk;
    logic      rst_n;
    ptw_req_t  ptw_req;
    core_req_t core_req;
    logic      ptw_ready;
    logic      ptw_rsp_valid;
    word_t     ptw_rsp_data;
    logic      core_ready;
    logic      core_rsp_valid;
    word_t     core_rsp_data;
    logic      mem_req_valid;
    mem_req_t  mem_req;
    logic      mem_req_ready;
    logic      mem_rsp_valid;
    mem_rsp_t  mem_rsp;
    pmu_cnt_t  pmu;
    pmu_cnt_t  exp_pmu;
    integer    seed;
    int        cycle_cnt;
    int        test_cnt;
    int        err_cnt;
    int        err_base;

    mem_tile u_dut (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .ptw_req_i        (ptw_req),
        .ptw_ready_o      (ptw_ready),
        .ptw_rsp_valid_o  (ptw_rsp_valid),
        .ptw_rsp_data_o   (ptw_rsp_data),
        .core_req_i       (core_req),
        .core_ready_o     (core_ready),
        .core_rsp_valid_o (core_rsp_valid),
        .core_rsp_data_o  (core_rsp_data),
        .mem_req_valid_o  (mem_req_valid),
        .mem_req_o        (mem_req),
        .mem_req_ready_i  (mem_req_ready),
        .mem_rsp_valid_i  (mem_rsp_valid),
        .mem_rsp_i        (mem_rsp),
        .pmu_o            (pmu)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //----------------------------------------------------------
    // Compare tasks
    //----------------------------------------------------------
    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_mreq(input string name, input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pmu(input string name, input pmu_cnt_t got, input pmu_cnt_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    //----------------------------------------------------------
    // Requester and memory models
    //----------------------------------------------------------
    // Tag and lane both visible in every response word
    function automatic word_t lane_pattern(input int tag, input int lane);
        return {16'hc0de, tag[15:0], 16'h5a5a, lane[15:0]};
    endfunction

    function automatic logic ready_of(input owner_e o);
        return (o == OWN_PTW) ? ptw_ready : core_ready;
    endfunction

    function automatic logic rsp_valid_of(input owner_e o);
        return (o == OWN_PTW) ? ptw_rsp_valid : core_rsp_valid;
    endfunction

    task automatic drive_ptw(input paddr_t addr, input logic [4:0] cmd, input logic [2:0] typ,
                             input word_t data);
        ptw_req <= '{valid: 1'b1, addr: addr, cmd: cmd, typ: typ, data: data};
        exp_pmu.ptw_reqs = exp_pmu.ptw_reqs + 1;
    endtask

    task automatic drive_core(input paddr_t addr, input logic is_store, input logic [2:0] size,
                              input word_t wdata, input be_t be);
        core_req <= '{valid: 1'b1, addr: addr, is_store: is_store, size: size,
                      wdata: wdata, be: be};
        if (is_store) begin
            exp_pmu.core_stores = exp_pmu.core_stores + 1;
        end else begin
            exp_pmu.core_loads = exp_pmu.core_loads + 1;
        end
    endtask

    // Checks the issued request, stalls, accepts, then answers once
    task automatic serve_request(input owner_e owner, input mem_req_t exp_req, input int stall,
                                 input int tag, input logic check_data, input int exp_lane);
        int       delay;
        mem_rsp_t rsp;
        owner_e   other;
        string    side;
        string    other_side;
        other      = (owner == OWN_PTW) ? OWN_CORE : OWN_PTW;
        side       = (owner == OWN_PTW) ? "ptw" : "core";
        other_side = (owner == OWN_PTW) ? "core" : "ptw";
        for (int i = 0; i < `MT_REQ_WORDS; i++) begin
            rsp.rdata[i] = lane_pattern(tag, i);
        end
        @(negedge clk);
        while (!mem_req_valid) begin
            @(negedge clk);
        end
        check_mreq("mem_req_o", mem_req, exp_req);
        for (int i = 0; i < stall; i++) begin
            check_bit({side, "_ready_o"}, ready_of(owner), 1'b0);
            check_bit({other_side, "_ready_o"}, ready_of(other), 1'b0);
            @(negedge clk);
            check_bit("mem_req_valid_o", mem_req_valid, 1'b1);
            check_mreq("mem_req_o", mem_req, exp_req);
        end
        @(posedge clk);
        mem_req_ready <= 1'b1;
        @(negedge clk);
        check_bit({side, "_ready_o"}, ready_of(owner), 1'b1);
        check_bit({other_side, "_ready_o"}, ready_of(other), 1'b0);
        @(posedge clk);
        mem_req_ready <= 1'b0;
        // Requester moves on after its ready, address included
        if (owner == OWN_PTW) begin
            ptw_req <= '0;
        end else begin
            core_req <= '0;
        end
        delay = (($random(seed) & 32'h7fff_ffff) % 5) + 1;
        repeat (delay) begin
            @(posedge clk);
        end
        mem_rsp_valid <= 1'b1;
        mem_rsp       <= rsp;
        @(negedge clk);
        check_bit({side, "_rsp_valid_o"}, rsp_valid_of(owner), 1'b1);
        check_bit({other_side, "_rsp_valid_o"}, rsp_valid_of(other), 1'b0);
        if (check_data) begin
            check_word({side, "_rsp_data_o"}, (owner == OWN_PTW) ? ptw_rsp_data : core_rsp_data,
                       lane_pattern(tag, exp_lane));
        end
        @(posedge clk);
        mem_rsp_valid <= 1'b0;
        mem_rsp       <= '0;
    endtask

    task automatic report_test(input string name);
        test_cnt++;
        if (err_cnt == err_base) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, err_cnt - err_base);
        end
        err_base = err_cnt;
    endtask

    //----------------------------------------------------------
    // Directed tests
    //----------------------------------------------------------
    task automatic test_reset();
        @(negedge clk);
        check_bit("mem_req_valid_o", mem_req_valid, 1'b0);
        check_bit("ptw_ready_o", ptw_ready, 1'b0);
        check_bit("core_ready_o", core_ready, 1'b0);
        check_bit("ptw_rsp_valid_o", ptw_rsp_valid, 1'b0);
        check_bit("core_rsp_valid_o", core_rsp_valid, 1'b0);
        check_pmu("pmu_o", pmu, '0);
        report_test("reset_state");
    endtask

    task automatic test_ptw() ;
        mem_req_t exp;
        exp      = '0;
        exp.addr = 40'h00_8000_1008;
        exp.op   = MEM_LOAD;
        exp.size = 3'd3;
        @(posedge clk);
        drive_ptw(40'h00_8000_1008, 5'h00, 3'd3, '0);
        serve_request(OWN_PTW, exp, 0, 2, 1'b1, 1);
        report_test("ptw_load_lane1");
        exp          = '0;
        exp.addr     = 40'h12_3456_7000;
        exp.op       = MEM_AMO_OR;
        exp.size     = 3'd3;
        exp.wdata[0] = 64'h0000_0000_0000_0100;
        exp.be[0]    = 8'hff;
        @(posedge clk);
        drive_ptw(40'h12_3456_7000, `MT_PTW_CMD_AMO_OR, 3'd3, 64'h0000_0000_0000_0100);
        serve_request(OWN_PTW, exp, 0, 3, 1'b1, 0);
        report_test("ptw_amo_or_lane0");
    endtask

    task automatic test_core();
        mem_req_t exp;
        exp          = '0;
        exp.addr     = 40'h00_0000_2000;
        exp.op       = MEM_STORE;
        exp.size     = 3'd2;
        exp.wdata[0] = 64'h0000_0000_cafe_f00d;
        exp.be[0]    = 8'h0f;
        @(posedge clk);
        drive_core(40'h00_0000_2000, 1'b1, 3'd2, 64'h0000_0000_cafe_f00d, 8'h0f);
        serve_request(OWN_CORE, exp, 0, 4, 1'b0, 0);
        report_test("core_store_lane0");
        exp       = '0;
        exp.addr  = 40'h00_0000_2008;
        exp.op    = MEM_LOAD;
        exp.size  = 3'd3;
        exp.be[1] = 8'hff;
        @(posedge clk);
        drive_core(40'h00_0000_2008, 1'b0, 3'd3, '0, 8'hff);
        serve_request(OWN_CORE, exp, 0, 5, 1'b1, 1);
        report_test("core_load_lane1");
    endtask

    // Same-cycle valids with the walker's request stalled
    task automatic test_priority();
        mem_req_t exp_ptw;
        mem_req_t exp_core;
        exp_ptw        = '0;
        exp_ptw.addr   = 40'h00_0040_0018;
        exp_ptw.op     = MEM_LOAD;
        exp_ptw.size   = 3'd3;
        exp_core       = '0;
        exp_core.addr  = 40'h00_0000_3000;
        exp_core.op    = MEM_LOAD;
        exp_core.size  = 3'd3;
        exp_core.be[0] = 8'hff;
        @(posedge clk);
        drive_ptw(40'h00_0040_0018, 5'h00, 3'd3, '0);
        drive_core(40'h00_0000_3000, 1'b0, 3'd3, '0, 8'hff);
        serve_request(OWN_PTW, exp_ptw, 4, 6, 1'b1, 1);
        serve_request(OWN_CORE, exp_core, 0, 7, 1'b1, 0);
        report_test("priority_and_stall");
    endtask

    //----------------------------------------------------------
    // Main sequence and watchdog
    //----------------------------------------------------------
    initial begin
        rst_n         = 1'b0;
        ptw_req       = '0;
        core_req      = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        exp_pmu       = '0;
        seed          = 11806;
        test_cnt      = 0;
        err_cnt       = 0;
        err_base      = 0;
        repeat (4) begin
            @(posedge clk);
        end
        rst_n <= 1'b1;
        test_reset();
        test_ptw();
        test_core();
        test_priority();
        @(negedge clk);
        check_pmu("pmu_o", pmu, exp_pmu);
        report_test("pmu_counts");
        $display("Summary: %0d tests, %0d errors", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/mem_tile_pkg.sv
rtl/dport_arbiter.sv
rtl/ptw_port.sv
rtl/core_port.sv
rtl/pmu_counters.sv
rtl/mem_tile.sv
sim/tb_mem_tile.sv
